// File: dv/core_slice_tb.sv
//************************************************
// Wishbone memory with random ack delay, random hold
// and an in-order writeback checker for the RV64I slice
// Program and expected writebacks come from dv/core_testdata.txt
//************************************************

module core_slice_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // ADDI x0, x0, 0
    localparam int          MAX_EXP  = 64;
    localparam int          DRAIN    = 60;

    logic                clk;
    logic                arst_n;
    logic                hold;
    logic                wb_ack;
    pipe_pkg::inst_t     wb_dat_i;
    logic                wb_cyc;
    logic                wb_stb;
    pipe_pkg::pc_t       wb_adr;
    logic                wb_ena;
    pipe_pkg::reg_addr_t wb_addr;
    pipe_pkg::xlen_t     wb_data;

    logic [31:0]  mem [0:63];
    logic [63:0]  prog_bytes;
    logic [4:0]   exp_rd [0:MAX_EXP-1];
    logic [63:0]  exp_data [0:MAX_EXP-1];
    logic [127:0] exp_name [0:MAX_EXP-1];

    int seed = 2752;
    int n_exp;
    int got;
    int checks;
    int errors;
    int cycles;
    int limit;
    int ack_wait;

    core_slice_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .hold     (hold),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_ena   (wb_ena),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    always #2 clk = ~clk;

    // Lines are tagged # for comments, I for program words, E for expected writebacks
    task automatic load_testdata();
        int           fd;
        int           code;
        logic         done;
        logic [7:0]   tag;
        logic [959:0] rest;
        logic [63:0]  addr;
        logic [31:0]  word;
        logic [4:0]   rd;
        logic [63:0]  val;
        logic [127:0] name;
        done = 1'b0;
        fd   = $fopen("dv/core_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/core_testdata.txt");
            errors++;
            return;
        end
        while (!done) begin
            tag  = 8'h00;
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h", addr, word);
                if (addr >= 64'd256) begin
                    $display("Program address %h lies outside the memory model", addr);
                    errors++;
                end else begin
                    mem[addr[7:2]] = word;
                    if (addr + 64'd4 > prog_bytes) prog_bytes = addr + 64'd4;
                end
            end else if (tag == "E" && n_exp < MAX_EXP) begin
                code = $fscanf(fd, "%d %h %s", rd, val, name);
                exp_rd[n_exp]   = rd;
                exp_data[n_exp] = val;
                exp_name[n_exp] = name;
                n_exp++;
            end else begin
                $display("Data file line with tag '%c' cannot be used", tag);
                errors++;
                done = 1'b1;
            end
        end
        $fclose(fd);
    endtask

    function automatic logic [31:0] fetch_word(input logic [63:0] adr);
        if (adr < prog_bytes) return mem[adr[7:2]];
        return NOP_WORD;  // Past the program the core only sees NOPs
    endfunction

    //************************************************
    // Wishbone memory model and random hold
    //************************************************
    always @(posedge clk) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            hold     <= 1'b0;
            ack_wait <= 0;
        end else begin
            hold <= ({$random(seed)} % 10 == 0);
            if (wb_cyc != wb_stb) begin
                $display("Wishbone cyc and stb differ (cyc %b, stb %b) at address %h",
                         wb_cyc, wb_stb, wb_adr);
                errors++;
            end
            if (wb_ack) begin
                wb_ack <= 1'b0;  // Master drops stb in the cycle after ack
            end else if (wb_stb) begin
                if (ack_wait == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_i <= fetch_word(wb_adr);
                    ack_wait <= {$random(seed)} % 4;
                end else begin
                    ack_wait <= ack_wait - 1;
                end
            end
        end
    end

    //************************************************
    // Writeback checker
    //************************************************
    always @(posedge clk) begin
        if (arst_n && wb_ena) begin
            if (got >= n_exp) begin
                $display("Unexpected writeback to x%0d with value %h", wb_addr, wb_data);
                errors++;
            end else begin
                checks++;
                if (wb_addr != exp_rd[got] || wb_data != exp_data[got]) begin
                    $display("[FAIL] %0s: expected x%0d = %h, actual x%0d = %h",
                             exp_name[got], exp_rd[got], exp_data[got], wb_addr, wb_data);
                    errors++;
                end
                got++;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        hold       = 1'b0;
        wb_ack     = 1'b0;
        wb_dat_i   = '0;
        prog_bytes = '0;
        n_exp      = 0;
        got        = 0;
        checks     = 0;
        errors     = 0;
        cycles     = 0;
        load_testdata();
        limit = 40 * n_exp + 200;
        if (n_exp == 0) begin
            $display("No expected writebacks were loaded");
            errors++;
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        // Poll on the falling edge so the checker's count has settled
        while (got < n_exp && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (got < n_exp) begin
            $display("Timeout after %0d cycles: only %0d of %0d writebacks arrived",
                     cycles, got, n_exp);
            errors++;
        end else begin
            repeat (DRAIN) @(negedge clk);  // Window for extra writebacks
        end
        $display("Writebacks checked: %0d of %0d, errors: %0d", checks, n_exp, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/core_testdata.txt
# I <byte address hex> <instruction hex>   program words in address order
# E <rd decimal> <value hex> <name>        expected writebacks in program order
I 00 00500093
I 04 FFD00113
I 08 002081B3
I 0C 40118233
I 10 0F024293
I 14 7FF2F313
I 18 0F036393
I 1C 02139413
I 20 123454B7
I 24 80000537
I 28 00A4E5B3
I 2C 00708013
I 30 00000000
I 34 0055C633
I 38 007676B3
I 3C 40C68733
I 40 00E700B3
I 44 00409793
E 1 0000000000000005 addi_pos
E 2 FFFFFFFFFFFFFFFD addi_neg
E 3 0000000000000002 add_dist1
E 4 FFFFFFFFFFFFFFFD sub_dist1
E 5 FFFFFFFFFFFFFF0D xori
E 6 000000000000070D andi
E 7 00000000000007FD ori
E 8 00000FFA00000000 slli_33
E 9 0000000012345000 lui_pos
E 10 FFFFFFFF80000000 lui_neg
E 11 FFFFFFFF92345000 or_dist2
E 12 000000006DCBAF0D xor_after_skip
E 13 000000000000070D and_dist1
E 14 FFFFFFFF92345800 sub_dist2
E 1 FFFFFFFF2468B000 add_same_src
E 15 FFFFFFF2468B0000 slli_4

// File: list.f
+incdir+source
source/pipe_pkg.sv
source/fetch_wb.sv
source/reg_file.sv
source/decode.sv
source/stall_ctrl.sv
source/id_ex.sv
source/alu_wb.sv
source/core_slice_top.sv
dv/core_slice_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module core_slice_tb \
    -o sim_core_slice > build.log 2>&1 &&
./obj_dir/sim_core_slice > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; } || exit 0

// File: source/alu_wb.sv
//************************************************
// 64-bit ALU and EX/WB result register
// wb_ena pulses once per instruction, also across a hold
//************************************************
`include "pipe_settings.svh"

module alu_wb (
    input  logic                clk,
    input  logic                arst_n,
    input  pipe_pkg::stall_t    stall_ctrl,
    input  pipe_pkg::alu_op_e   ex_alu_op,
    input  pipe_pkg::xlen_t     ex_op1,
    input  pipe_pkg::xlen_t     ex_op2,
    input  logic                ex_rd_ena,
    input  pipe_pkg::reg_addr_t ex_rd_addr,
    output logic                wb_ena,
    output pipe_pkg::reg_addr_t wb_addr,
    output pipe_pkg::xlen_t     wb_data
);

    pipe_pkg::xlen_t result;

    always_comb begin
        case (ex_alu_op)
            pipe_pkg::SUB: result = ex_op1 - ex_op2;
            pipe_pkg::AND: result = ex_op1 & ex_op2;
            pipe_pkg::OR:  result = ex_op1 | ex_op2;
            pipe_pkg::XOR: result = ex_op1 ^ ex_op2;
            pipe_pkg::SLL: result = ex_op1 << ex_op2[5:0];
            default:       result = ex_op1 + ex_op2;  // ADD and LUI
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ena  <= 1'b0;
            wb_addr <= '0;
            wb_data <= '0;
        end else if (stall_ctrl[`PIPE_STALL_ALL]) begin
            wb_ena <= 1'b0;  // The write already landed, so do not repeat it
        end else begin
            wb_ena  <= ex_rd_ena;
            wb_addr <= ex_rd_addr;
            wb_data <= result;
        end
    end

    // x0 destinations are dropped in decode
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        wb_ena |-> wb_addr != '0);

endmodule

// File: source/core_slice_top.sv
//************************************************
// RV64I integer slice: fetch, decode, execute, writeback
// Wishbone classic on instruction fetch only; hold freezes all
//************************************************

module core_slice_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                hold,
    input  logic                wb_ack,
    input  pipe_pkg::inst_t     wb_dat_i,
    output logic                wb_cyc,
    output logic                wb_stb,
    output pipe_pkg::pc_t       wb_adr,
    output logic                wb_ena,
    output pipe_pkg::reg_addr_t wb_addr,
    output pipe_pkg::xlen_t     wb_data
);

    pipe_pkg::stall_t     stall_ctrl;

    pipe_pkg::inst_t      ifid_inst;
    pipe_pkg::pc_t        ifid_pc;
    logic                 ifid_valid;

    pipe_pkg::reg_addr_t  rs1_addr;
    pipe_pkg::reg_addr_t  rs2_addr;
    logic                 rs1_used;
    logic                 rs2_used;
    pipe_pkg::xlen_t      rs1_data;
    pipe_pkg::xlen_t      rs2_data;

    pipe_pkg::inst_t      id_inst;
    pipe_pkg::pc_t        id_pc;
    pipe_pkg::inst_type_e id_inst_type;
    pipe_pkg::alu_op_e    id_alu_op;
    pipe_pkg::xlen_t      id_op1;
    pipe_pkg::xlen_t      id_op2;
    logic                 id_rd_ena;
    pipe_pkg::reg_addr_t  id_rd_addr;
    logic                 id_bubble;

    pipe_pkg::alu_op_e    ex_alu_op;
    pipe_pkg::xlen_t      ex_op1;
    pipe_pkg::xlen_t      ex_op2;
    logic                 ex_rd_ena;
    pipe_pkg::reg_addr_t  ex_rd_addr;

    fetch_wb u_fetch_wb (.*);

    reg_file u_reg_file (.*);

    decode u_decode (.*);

    stall_ctrl u_stall_ctrl (.*);

    // Instruction, PC and type ride along for debug only
    id_ex u_id_ex (
        .ex_inst      (),
        .ex_pc        (),
        .ex_inst_type (),
        .*
    );

    alu_wb u_alu_wb (.*);

endmodule

// File: source/decode.sv
//************************************************
// Decoder for ADDI ANDI ORI XORI SLLI ADD SUB AND OR XOR LUI
// Any other encoding becomes a bubble with no writeback
//************************************************
`include "pipe_settings.svh"

module decode (
    input  pipe_pkg::inst_t      ifid_inst,
    input  pipe_pkg::pc_t        ifid_pc,
    input  logic                 ifid_valid,
    input  pipe_pkg::xlen_t      rs1_data,
    input  pipe_pkg::xlen_t      rs2_data,
    output pipe_pkg::reg_addr_t  rs1_addr,
    output pipe_pkg::reg_addr_t  rs2_addr,
    output logic                 rs1_used,
    output logic                 rs2_used,
    output pipe_pkg::inst_t      id_inst,
    output pipe_pkg::pc_t        id_pc,
    output pipe_pkg::inst_type_e id_inst_type,
    output pipe_pkg::alu_op_e    id_alu_op,
    output pipe_pkg::xlen_t      id_op1,
    output pipe_pkg::xlen_t      id_op2,
    output logic                 id_rd_ena,
    output pipe_pkg::reg_addr_t  id_rd_addr,
    output logic                 id_bubble
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    pipe_pkg::xlen_t imm_i;
    pipe_pkg::xlen_t imm_u;
    logic            supported;
    logic            use_rs1;
    logic            use_rs2;

    assign opcode     = ifid_inst[6:0];
    assign funct3     = ifid_inst[14:12];
    assign funct7     = ifid_inst[31:25];
    assign rs1_addr   = ifid_inst[19:15];
    assign rs2_addr   = ifid_inst[24:20];
    assign id_rd_addr = ifid_inst[11:7];
    assign id_inst    = ifid_inst;
    assign id_pc      = ifid_pc;

    assign imm_i = {{(`PIPE_XLEN-12){ifid_inst[31]}}, ifid_inst[31:20]};
    assign imm_u = {{(`PIPE_XLEN-32){ifid_inst[31]}}, ifid_inst[31:12], 12'b0};

    always_comb begin
        supported    = 1'b1;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        id_inst_type = pipe_pkg::NONE;
        id_alu_op    = pipe_pkg::ADD;
        id_op1       = rs1_data;
        id_op2       = imm_i;
        case (opcode)
            OPC_OP_IMM: begin
                id_inst_type = pipe_pkg::ALU_IMM;
                use_rs1      = 1'b1;
                case (funct3)
                    3'b000:  id_alu_op = pipe_pkg::ADD;
                    3'b100:  id_alu_op = pipe_pkg::XOR;
                    3'b110:  id_alu_op = pipe_pkg::OR;
                    3'b111:  id_alu_op = pipe_pkg::AND;
                    3'b001: begin
                        id_alu_op = pipe_pkg::SLL;
                        supported = (funct7[6:1] == 6'b0);  // RV64 shamt uses bit 25
                    end
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP: begin
                id_inst_type = pipe_pkg::ALU_REG;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                id_op2       = rs2_data;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: id_alu_op = pipe_pkg::ADD;
                    {7'b0100000, 3'b000}: id_alu_op = pipe_pkg::SUB;
                    {7'b0000000, 3'b100}: id_alu_op = pipe_pkg::XOR;
                    {7'b0000000, 3'b110}: id_alu_op = pipe_pkg::OR;
                    {7'b0000000, 3'b111}: id_alu_op = pipe_pkg::AND;
                    default:              supported = 1'b0;
                endcase
            end
            OPC_LUI: begin
                id_inst_type = pipe_pkg::UPPER;  // Computed as 0 + imm_u
                id_op1       = '0;
                id_op2       = imm_u;
            end
            default: supported = 1'b0;
        endcase
    end

    assign id_bubble = !ifid_valid || !supported;
    assign rs1_used  = use_rs1 && !id_bubble;
    assign rs2_used  = use_rs2 && !id_bubble;
    assign id_rd_ena = !id_bubble && (id_rd_addr != '0);

endmodule

// File: source/fetch_wb.sv
//************************************************
// Wishbone classic instruction fetch, one read outstanding
// Memory must answer every stb with ack; no err or retry
// A fetched word waits in a one-entry buffer until IF/ID takes it
//************************************************
`include "pipe_settings.svh"

module fetch_wb (
    input  logic             clk,
    input  logic             arst_n,
    input  pipe_pkg::stall_t stall_ctrl,
    input  logic             wb_ack,
    input  pipe_pkg::inst_t  wb_dat_i,
    output logic             wb_cyc,
    output logic             wb_stb,
    output pipe_pkg::pc_t    wb_adr,
    output pipe_pkg::inst_t  ifid_inst,
    output pipe_pkg::pc_t    ifid_pc,
    output logic             ifid_valid
);

    pipe_pkg::fetch_state_e state;
    pipe_pkg::pc_t          pc;
    pipe_pkg::inst_t        fetch_buf;
    logic                   ifid_hold;
    logic                   word_move;

    assign ifid_hold = stall_ctrl[`PIPE_STALL_PC] | stall_ctrl[`PIPE_STALL_IFID];
    assign word_move = (state == pipe_pkg::DONE) && !ifid_hold;

    // Bus strobes follow the state, so they drop the cycle after ack
    assign wb_cyc = (state == pipe_pkg::BUS);
    assign wb_stb = (state == pipe_pkg::BUS);
    assign wb_adr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= pipe_pkg::IDLE;
            pc        <= `PIPE_RESET_PC;
            fetch_buf <= '0;
        end else begin
            case (state)
                pipe_pkg::IDLE: begin
                    if (!stall_ctrl[`PIPE_STALL_ALL]) begin
                        state <= pipe_pkg::BUS;
                    end
                end
                pipe_pkg::BUS: begin
                    if (wb_ack) begin  // Captured even while hold is high
                        fetch_buf <= wb_dat_i;
                        state     <= pipe_pkg::DONE;
                    end
                end
                pipe_pkg::DONE: begin
                    if (word_move) begin
                        pc    <= pc + pipe_pkg::pc_t'(4);
                        state <= pipe_pkg::BUS;
                    end
                end
                default: state <= pipe_pkg::IDLE;
            endcase
        end
    end

    //************************************************
    // IF/ID register
    //************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifid_valid <= 1'b0;
            ifid_inst  <= '0;
            ifid_pc    <= '0;
        end else if (!ifid_hold) begin
            ifid_valid <= word_move;  // Invalid when no word is ready
            if (word_move) begin
                ifid_inst <= fetch_buf;
                ifid_pc   <= pc;
            end
        end
    end

    // A pending request keeps its address and strobe until ack
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

// File: source/id_ex.sv
//************************************************
// ID/EX register: pass or bubble, hold on all ones,
// bubble on the hazard pattern
//************************************************
`include "pipe_settings.svh"

module id_ex (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pipe_pkg::stall_t     stall_ctrl,
    input  logic                 id_bubble,
    input  pipe_pkg::inst_t      id_inst,
    input  pipe_pkg::pc_t        id_pc,
    input  pipe_pkg::inst_type_e id_inst_type,
    input  pipe_pkg::alu_op_e    id_alu_op,
    input  pipe_pkg::xlen_t      id_op1,
    input  pipe_pkg::xlen_t      id_op2,
    input  logic                 id_rd_ena,
    input  pipe_pkg::reg_addr_t  id_rd_addr,
    output pipe_pkg::inst_t      ex_inst,
    output pipe_pkg::pc_t        ex_pc,
    output pipe_pkg::inst_type_e ex_inst_type,
    output pipe_pkg::alu_op_e    ex_alu_op,
    output pipe_pkg::xlen_t      ex_op1,
    output pipe_pkg::xlen_t      ex_op2,
    output logic                 ex_rd_ena,
    output pipe_pkg::reg_addr_t  ex_rd_addr
);

    logic run;
    logic hold_all;
    logic hazard;
    logic clear;

    assign run      = !stall_ctrl[`PIPE_STALL_IDEX]
                    && (stall_ctrl[`PIPE_STALL_ALL:`PIPE_STALL_EXWB] == '0);
    assign hold_all = &stall_ctrl;
    assign hazard   = stall_ctrl[`PIPE_STALL_PC] && stall_ctrl[`PIPE_STALL_IFID]
                    && stall_ctrl[`PIPE_STALL_IDEX] && !stall_ctrl[`PIPE_STALL_EXWB];
    assign clear    = hazard || (run && id_bubble);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_inst      <= '0;
            ex_pc        <= '0;
            ex_inst_type <= pipe_pkg::NONE;
            ex_alu_op    <= pipe_pkg::ADD;
            ex_op1       <= '0;
            ex_op2       <= '0;
            ex_rd_ena    <= 1'b0;
            ex_rd_addr   <= '0;
        end else if (clear) begin
            ex_inst      <= '0;
            ex_pc        <= '0;
            ex_inst_type <= pipe_pkg::NONE;
            ex_alu_op    <= pipe_pkg::ADD;
            ex_op1       <= '0;
            ex_op2       <= '0;
            ex_rd_ena    <= 1'b0;
            ex_rd_addr   <= '0;
        end else if (!hold_all) begin
            ex_inst      <= id_inst;
            ex_pc        <= id_pc;
            ex_inst_type <= id_inst_type;
            ex_alu_op    <= id_alu_op;
            ex_op1       <= id_op1;
            ex_op2       <= id_op2;
            ex_rd_ena    <= id_rd_ena;
            ex_rd_addr   <= id_rd_addr;
        end
    end

endmodule

// File: source/pipe_pkg.sv
//************************************************
// Shared types of the pipeline slice
// Enum encodings are internal and never leave the core
//************************************************
`include "pipe_settings.svh"

package pipe_pkg;

    typedef logic [`PIPE_XLEN-1:0]    xlen_t;
    typedef logic [`PIPE_XLEN-1:0]    pc_t;
    typedef logic [`PIPE_INST_W-1:0]  inst_t;
    typedef logic [`PIPE_REG_AW-1:0]  reg_addr_t;
    typedef logic [`PIPE_STALL_ALL:0] stall_t;  // One bit per stage plus the global hold

    typedef enum logic [2:0] {
        NONE,
        ALU_IMM,
        ALU_REG,
        UPPER
    } inst_type_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } fetch_state_e;

endpackage

// File: source/pipe_settings.svh
//************************************************
// Widths, reset PC and stall bit positions of the RV64I slice
// Stall bits are indices into the five-bit stall vector
//************************************************
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

`define PIPE_XLEN      64
`define PIPE_INST_W    32
`define PIPE_REG_AW    5
`define PIPE_RESET_PC  64'h0

`define PIPE_STALL_PC    0  // Hold the PC
`define PIPE_STALL_IFID  1  // Hold IF/ID
`define PIPE_STALL_IDEX  2  // Stop ID/EX
`define PIPE_STALL_EXWB  3  // Hold EX/WB
`define PIPE_STALL_ALL   4  // Global hold

`endif

// File: source/reg_file.sv
//************************************************
// 32 x 64 register file, asynchronous read, x0 reads zero
// Same-cycle write data is bypassed to the read ports
//************************************************
`include "pipe_settings.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  pipe_pkg::reg_addr_t rs1_addr,
    input  pipe_pkg::reg_addr_t rs2_addr,
    input  logic                wb_ena,
    input  pipe_pkg::reg_addr_t wb_addr,
    input  pipe_pkg::xlen_t     wb_data,
    output pipe_pkg::xlen_t     rs1_data,
    output pipe_pkg::xlen_t     rs2_data
);

    pipe_pkg::xlen_t regs [2**`PIPE_REG_AW];
    logic            write_ok;

    assign write_ok = wb_ena && (wb_addr != '0);  // x0 is never written

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**`PIPE_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (write_ok) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rs1_data = (write_ok && (wb_addr == rs1_addr)) ? wb_data : regs[rs1_addr];
    assign rs2_data = (write_ok && (wb_addr == rs2_addr)) ? wb_data : regs[rs2_addr];

endmodule

// File: source/stall_ctrl.sv
//************************************************
// Stall vector: all ones on hold, PC+IF/ID+ID/EX on a hazard
// Only the ID/EX destination is checked; WB is covered by bypass
//************************************************
`include "pipe_settings.svh"

module stall_ctrl (
    input  logic                hold,
    input  pipe_pkg::reg_addr_t rs1_addr,
    input  pipe_pkg::reg_addr_t rs2_addr,
    input  logic                rs1_used,
    input  logic                rs2_used,
    input  logic                ex_rd_ena,
    input  pipe_pkg::reg_addr_t ex_rd_addr,
    output pipe_pkg::stall_t    stall_ctrl
);

    localparam pipe_pkg::stall_t HAZARD_VEC = pipe_pkg::stall_t'((1 << `PIPE_STALL_PC)
        | (1 << `PIPE_STALL_IFID) | (1 << `PIPE_STALL_IDEX));

    logic hit1;
    logic hit2;

    assign hit1 = rs1_used && (rs1_addr == ex_rd_addr) && (rs1_addr != '0);
    assign hit2 = rs2_used && (rs2_addr == ex_rd_addr) && (rs2_addr != '0);

    always_comb begin
        stall_ctrl = '0;
        if (hold) begin
            stall_ctrl = '1;  // Everything freezes
        end else if (ex_rd_ena && (hit1 || hit2)) begin
            stall_ctrl = HAZARD_VEC;
        end
    end

    // id_ex and fetch_wb only decode these three patterns
    always_comb begin
        a_legal_vec: assert (stall_ctrl == '0 || stall_ctrl == '1 || stall_ctrl == HAZARD_VEC)
            else $error("illegal stall vector %b", stall_ctrl);
    end

endmodule
